// File: compile.f
+incdir+dv
hdl/branch_pkg.sv
hdl/branch_unit.sv
hdl/local_predictor.sv
hdl/global_predictor.sv
hdl/tournament_chooser.sv
hdl/branch_predict_top.sv
dv/branch_tb.sv

// File: Bender.yml
package:
  name: branch_predict

sources:
  - hdl/branch_pkg.sv
  - hdl/branch_unit.sv
  - hdl/local_predictor.sv
  - hdl/global_predictor.sv
  - hdl/tournament_chooser.sv
  - hdl/branch_predict_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/branch_tb.sv

// File: dv/branch_model.svh
`default_nettype none

// Software copy of the predictor tables at the top level's default sizes
localparam int hist_index_bits = 6;
localparam int hist_len        = 4;
localparam int ghr_len         = 6;
localparam int chooser_bits    = 6;

logic [hist_len-1:0] hist_copy    [2**hist_index_bits];
logic [1:0]          local_copy   [2**hist_len];
logic [1:0]          gshare_copy  [2**ghr_len];
logic [1:0]          chooser_copy [2**chooser_bits];  // Upper half prefers global
logic [ghr_len-1:0]  ghr_copy;

function automatic logic expected_condition(input branch_pkg::branch_func_e f,
		input logic [31:0] a, input logic [31:0] b);
	logic signed_lt;
	signed_lt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);  // Bias turns signed order unsigned
	case (f)
		branch_pkg::beq:  return a == b;
		branch_pkg::bne:  return a != b;
		branch_pkg::blt:  return signed_lt;
		branch_pkg::bge:  return !signed_lt;
		branch_pkg::bltu: return a < b;
		branch_pkg::bgeu: return !(a < b);
		default:          return 1'b0;
	endcase
endfunction

function automatic logic [31:0] expected_next_pc(input logic taken, input logic [31:0] pcv,
		input logic [31:0] off);
	return taken ? pcv + off : pcv + 32'd4;
endfunction

function automatic logic [1:0] counter_step(input logic [1:0] c, input logic up);
	if (up)
		return (c == 2'd3) ? c : c + 2'd1;
	return (c == 2'd0) ? c : c - 2'd1;
endfunction

// Result packed as {taken, local, global}
function automatic logic [2:0] predict_from_model(input logic [31:0] pcv);
	logic l;
	logic g;
	l = local_copy[hist_copy[pcv[2 +: hist_index_bits]]][1];
	g = gshare_copy[pcv[2 +: ghr_len] ^ ghr_copy][1];
	return {chooser_copy[pcv[2 +: chooser_bits]][1] ? g : l, l, g};
endfunction

task automatic train_model(input logic [31:0] pcv, input logic taken, input logic lp,
		input logic gp);
	logic [hist_len-1:0]     h;
	logic [ghr_len-1:0]      gi;
	logic [chooser_bits-1:0] ci;
	h  = hist_copy[pcv[2 +: hist_index_bits]];
	gi = pcv[2 +: ghr_len] ^ ghr_copy;
	ci = pcv[2 +: chooser_bits];
	local_copy[h] = counter_step(local_copy[h], taken);
	hist_copy[pcv[2 +: hist_index_bits]] = {h[hist_len-2:0], taken};
	gshare_copy[gi] = counter_step(gshare_copy[gi], taken);
	ghr_copy = {ghr_copy[ghr_len-2:0], taken};
	if ((lp == taken) != (gp == taken))
		chooser_copy[ci] = counter_step(chooser_copy[ci], gp == taken);  // Toward the lone winner
endtask

task automatic clear_model();
	foreach (hist_copy[i])
		hist_copy[i] = '0;
	foreach (local_copy[i])
		local_copy[i] = 2'd1;  // Weakly not taken
	foreach (gshare_copy[i])
		gshare_copy[i] = 2'd1;
	foreach (chooser_copy[i])
		chooser_copy[i] = 2'd1;
	ghr_copy = '0;
endtask

`default_nettype wire

// File: dv/branch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module branch_tb;

	typedef struct packed {
		branch_pkg::branch_func_e             func;
		logic [branch_pkg::xlen-1:0]          a, b, pc, off, pnext;
		logic [branch_pkg::prf_len-1:0]       prf;
		logic [branch_pkg::rob_len-1:0]       rob;
		logic                                 is_cond, lp, gp;
	} packet_t;

	localparam int timeout_cycles = 16;

	logic clock, reset, predict_valid, issue_valid, cdb_broadcast_is_branch;
	logic cond_branch, uncond_branch, local_pred_direction, global_pred_direction;
	logic [branch_pkg::xlen-1:0] predict_pc, opa_value, opb_value, pc, offset, pred_next_pc;
	branch_pkg::branch_func_e branch_func;
	logic [branch_pkg::prf_len-1:0] dest_preg_idx, br_prf_idx;
	logic [branch_pkg::rob_len-1:0] rob_idx, br_rob_idx;
	logic br_valid, br_direction, br_mis_pred, br_cond_branch, br_uncond_branch, br_retire;
	logic br_local_pred_direction, br_global_pred_direction;
	logic [branch_pkg::xlen-1:0] br_target_pc, br_next_pc, br_pc;
	logic predict_out_valid, predict_taken, predict_local, predict_global;
	logic [31:0] rng_state;
	packet_t held;  // Branch the DUT should be holding

	branch_pkg::branch_func_e funcs [6] = '{branch_pkg::beq, branch_pkg::bne, branch_pkg::blt,
		branch_pkg::bge, branch_pkg::bltu, branch_pkg::bgeu};
	// Equal, sign-differing and extreme operand pairs
	logic [31:0] edge_a [8] = '{32'd0, 32'd5, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff,
		32'd1, 32'hffff_ffff, 32'd0};
	logic [31:0] edge_b [8] = '{32'd0, 32'd5, 32'h7fff_ffff, 32'h8000_0000, 32'd1,
		32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000};

	branch_predict_top branch_predict_top_inst (.*);

	always #20 clock = ~clock;

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic packet_t random_packet(input branch_pkg::branch_func_e f,
			input logic [31:0] a, input logic [31:0] b, input logic is_cond);
		packet_t p;
		logic [31:0] r;
		logic [31:0] s;
		r = next_random();
		s = next_random();
		p = '{func: f, a: a, b: b, pc: {r[31:2], 2'b00}, off: {{20{s[11]}}, s[11:1], 1'b0},
			pnext: 32'd0, prf: s[17:12], rob: s[22:18], is_cond: is_cond, lp: s[23], gp: s[24]};
		case (s[26:25])
			2'd0:    p.pnext = p.pc + 32'd4;
			2'd1:    p.pnext = p.pc + p.off;
			default: p.pnext = p.pc + 32'd8;  // Always wrong
		endcase
		return p;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_direction(input branch_pkg::branch_func_e f, input logic got,
			input logic exp);
		if (got !== exp)
			fail_run($sformatf("ERR @%0t: %s %h, %h gave %b, expected %b", $time, f.name(),
				held.a, held.b, got, exp));
	endtask

	task automatic check_pc(input string what, input logic [branch_pkg::xlen-1:0] got,
			input logic [branch_pkg::xlen-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR @%0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("ERR @%0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_passthrough(input packet_t p);
		if ({br_prf_idx, br_rob_idx, br_cond_branch, br_uncond_branch, br_local_pred_direction,
				br_global_pred_direction} !== {p.prf, p.rob, p.is_cond, !p.is_cond, p.lp, p.gp})
			fail_run($sformatf("ERR @%0t: pass-through fields differ for rob %0d", $time, p.rob));
	endtask

	task automatic check_prediction(input logic [31:0] pcv, input logic [2:0] exp);
		if ({predict_taken, predict_local, predict_global} !== exp)
			fail_run($sformatf("ERR @%0t: prediction at %h is %b, expected %b", $time, pcv,
				{predict_taken, predict_local, predict_global}, exp));
	endtask

	task automatic wait_for_br_valid();
		int cycles;
		cycles = 0;
		while (!br_valid) begin
			if (cycles == timeout_cycles)
				fail_run("Timeout: br_valid never rose after an issue");
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic wait_for_prediction();
		int cycles;
		cycles = 0;
		while (!predict_out_valid) begin
			if (cycles == timeout_cycles)
				fail_run("Timeout: predict_out_valid never rose after a lookup");
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic drive_issue(input packet_t p);
		{opa_value, opb_value, pc, offset, pred_next_pc} = {p.a, p.b, p.pc, p.off, p.pnext};
		branch_func = p.func;
		{dest_preg_idx, rob_idx} = {p.prf, p.rob};
		{cond_branch, uncond_branch} = {p.is_cond, !p.is_cond};
		{local_pred_direction, global_pred_direction} = {p.lp, p.gp};
		issue_valid = 1'b1;
	endtask

	task automatic issue(input packet_t p);
		drive_issue(p);
		@(negedge clock);
		issue_valid = 1'b0;
		held = p;
		wait_for_br_valid();
		@(negedge clock);  // Idle cycle
		check_flag("br_valid while held", br_valid, 1'b1);
		check_flag("br_retire while held", br_retire, 1'b0);
	endtask

	// Next issue may share the broadcast cycle
	task automatic broadcast(input logic reissue, input packet_t p);
		cdb_broadcast_is_branch = 1'b1;
		if (reissue)
			drive_issue(p);
		@(posedge clock);
		check_flag("br_retire on broadcast", br_retire, 1'b1);
		@(negedge clock);
		{cdb_broadcast_is_branch, issue_valid} = 2'b00;
		if (held.is_cond)
			train_model(held.pc, expected_condition(held.func, held.a, held.b), held.lp, held.gp);
		if (reissue)
			held = p;
		check_flag("br_valid after broadcast", br_valid, reissue);
	endtask

	task automatic check_resolution();
		logic        taken;
		logic [31:0] next_exp;
		taken = held.is_cond ? expected_condition(held.func, held.a, held.b) : 1'b1;
		next_exp = expected_next_pc(taken, held.pc, held.off);
		if (held.is_cond)
			check_direction(held.func, br_direction, taken);
		else
			check_flag("jump direction", br_direction, 1'b1);
		check_pc("br_pc", br_pc, held.pc);
		check_pc("br_target_pc", br_target_pc, held.pc + held.off);
		check_pc("br_next_pc", br_next_pc, next_exp);
		check_flag("br_mis_pred", br_mis_pred, held.pnext != next_exp);
		check_passthrough(held);
	endtask

	task automatic resolve(input packet_t p);
		issue(p);
		check_resolution();
		broadcast(1'b0, p);
	endtask

	task automatic predict_and_resolve(input logic [31:0] pcv, input logic taken);
		logic [2:0] exp;
		packet_t    p;
		exp = predict_from_model(pcv);
		predict_valid = 1'b1;
		predict_pc = pcv;
		@(negedge clock);
		predict_valid = 1'b0;
		wait_for_prediction();
		check_prediction(pcv, exp);
		// Fetch records both directions and the chosen next PC
		p = random_packet(branch_pkg::beq, 32'd7, taken ? 32'd7 : 32'd9, 1'b1);
		p.pc = pcv;
		p.lp = exp[1];
		p.gp = exp[0];
		p.pnext = exp[2] ? pcv + p.off : pcv + 32'd4;
		resolve(p);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		rng_state = 32'h708a0ea3;
		{predict_valid, issue_valid, cdb_broadcast_is_branch} = 3'b000;
		{cond_branch, uncond_branch, local_pred_direction, global_pred_direction} = 4'b0000;
		{predict_pc, opa_value, opb_value, pc, offset, pred_next_pc} = '0;
		{dest_preg_idx, rob_idx} = '0;
		branch_func = branch_pkg::beq;
		held = '0;
		clear_model();
		repeat (5) @(negedge clock);
		reset = 1'b0;
		check_flag("br_valid after reset", br_valid, 1'b0);
		check_flag("br_retire after reset", br_retire, 1'b0);
		check_flag("predict_out_valid after reset", predict_out_valid, 1'b0);
		foreach (funcs[f]) begin
			foreach (edge_a[e])
				resolve(random_packet(funcs[f], edge_a[e], edge_b[e], 1'b1));
			repeat (6)
				resolve(random_packet(funcs[f], next_random(), next_random(), 1'b1));
		end
		repeat (6)
			resolve(random_packet(branch_pkg::bltu, next_random(), next_random(), 1'b0));  // Jumps
		// Second issue lands in the broadcast cycle of the first
		issue(random_packet(branch_pkg::bne, 32'd3, 32'd4, 1'b1));
		check_resolution();
		broadcast(1'b1, random_packet(branch_pkg::blt, 32'hffff_fff0, 32'd2, 1'b1));
		check_resolution();
		broadcast(1'b0, held);
		repeat (8)
			predict_and_resolve(32'h0000_1040, 1'b1);  // Loop branch
		for (int i = 0; i < 24; i++)
			predict_and_resolve(32'h0000_2a0c, i[0]);  // Alternating pattern
		$display("Test OK");
		$finish;
	end

	`include "branch_model.svh"

endmodule

`default_nettype wire

// File: hdl/branch_predict_top.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predict_top #(
	parameter int local_index_bits    = 6,
	parameter int local_history_bits  = 4,
	parameter int global_history_bits = 6,
	parameter int chooser_index_bits  = 6
) (
	input  wire logic                           clock,
	input  wire logic                           reset,
	input  wire logic                           predict_valid,
	input  wire logic [branch_pkg::xlen-1:0]    predict_pc,
	input  wire logic                           issue_valid,
	input  wire logic                           cdb_broadcast_is_branch,
	input  wire logic [branch_pkg::xlen-1:0]    opa_value,
	input  wire logic [branch_pkg::xlen-1:0]    opb_value,
	input  wire logic [branch_pkg::xlen-1:0]    pc,
	input  wire logic [branch_pkg::xlen-1:0]    offset,
	input  wire logic [branch_pkg::xlen-1:0]    pred_next_pc,
	input  wire branch_pkg::branch_func_e       branch_func,
	input  wire logic [branch_pkg::prf_len-1:0] dest_preg_idx,
	input  wire logic [branch_pkg::rob_len-1:0] rob_idx,
	input  wire logic                           cond_branch,
	input  wire logic                           uncond_branch,
	input  wire logic                           local_pred_direction,
	input  wire logic                           global_pred_direction,
	output logic                                br_valid,
	output logic                                br_direction,
	output logic                                br_mis_pred,
	output logic                                br_cond_branch,
	output logic                                br_uncond_branch,
	output logic                                br_local_pred_direction,
	output logic                                br_global_pred_direction,
	output logic [branch_pkg::xlen-1:0]         br_target_pc,
	output logic [branch_pkg::xlen-1:0]         br_next_pc,
	output logic [branch_pkg::xlen-1:0]         br_pc,
	output logic [branch_pkg::prf_len-1:0]      br_prf_idx,
	output logic [branch_pkg::rob_len-1:0]      br_rob_idx,
	output logic                                br_retire,
	output logic                                predict_out_valid,
	output logic                                predict_taken,
	output logic                                predict_local,
	output logic                                predict_global
);

	logic local_taken;
	logic global_taken;
	logic train_valid;  // From chooser to both predictors
	logic train_taken;

	branch_unit branch_unit_inst (.*);

	local_predictor #(
		.local_index_bits   (local_index_bits),
		.local_history_bits (local_history_bits)
	) local_predictor_inst (
		.clock, .reset,
		.lookup_valid (predict_valid),
		.lookup_pc    (predict_pc),
		.train_pc     (br_pc),
		.train_valid, .train_taken, .local_taken
	);

	global_predictor #(
		.global_history_bits (global_history_bits)
	) global_predictor_inst (
		.clock, .reset,
		.lookup_valid (predict_valid),
		.lookup_pc    (predict_pc),
		.train_pc     (br_pc),
		.train_valid, .train_taken, .global_taken
	);

	tournament_chooser #(
		.chooser_index_bits (chooser_index_bits)
	) tournament_chooser_inst (
		.clock, .reset,
		.lookup_valid (predict_valid),
		.lookup_pc    (predict_pc),
		.br_pc, .local_taken, .global_taken,
		.br_retire, .br_cond_branch, .br_direction,
		.br_local_pred_direction, .br_global_pred_direction,
		.predict_out_valid, .predict_taken, .predict_local, .predict_global,
		.train_valid, .train_taken
	);

endmodule

`default_nettype wire

// File: hdl/tournament_chooser.sv
`timescale 1ns/1ns
`default_nettype none

// Taken side of the selector table prefers global
module tournament_chooser #(
	parameter int chooser_index_bits = 6
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        lookup_valid,
	input  wire logic [branch_pkg::xlen-1:0] lookup_pc,
	input  wire logic [branch_pkg::xlen-1:0] br_pc,
	input  wire logic                        local_taken,
	input  wire logic                        global_taken,
	input  wire logic                        br_retire,
	input  wire logic                        br_cond_branch,
	input  wire logic                        br_direction,
	input  wire logic                        br_local_pred_direction,
	input  wire logic                        br_global_pred_direction,
	output logic                             predict_out_valid,
	output logic                             predict_taken,
	output logic                             predict_local,
	output logic                             predict_global,
	output logic                             train_valid,
	output logic                             train_taken
);

	localparam int chooser_entries = 2 ** chooser_index_bits;

	branch_pkg::counter_e          chooser_table [chooser_entries];
	logic [chooser_index_bits-1:0] lookup_idx;
	logic [chooser_index_bits-1:0] train_idx;
	logic                          select_global;
	logic                          local_right;
	logic                          global_right;

	assign lookup_idx = lookup_pc[2 +: chooser_index_bits];
	assign train_idx  = br_pc[2 +: chooser_index_bits];

	// Registered alongside the predictors' directions
	always_ff @(posedge clock) begin
		if (lookup_valid)
			select_global <= branch_pkg::counter_taken(chooser_table[lookup_idx]);
	end

	always_ff @(posedge clock) begin
		if (reset)
			predict_out_valid <= 1'b0;
		else
			predict_out_valid <= lookup_valid;  // Fixed one-cycle latency
	end

	assign predict_local  = local_taken;
	assign predict_global = global_taken;
	assign predict_taken  = select_global ? global_taken : local_taken;

	// Jumps do not train anything
	assign train_valid  = br_retire && br_cond_branch;
	assign train_taken  = br_direction;
	assign local_right  = br_local_pred_direction == br_direction;
	assign global_right = br_global_pred_direction == br_direction;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < chooser_entries; i++)
				chooser_table[i] <= branch_pkg::weak_not_taken;
		end else if (train_valid && (local_right != global_right)) begin
			// Step toward whichever side alone was right
			chooser_table[train_idx] <=
				branch_pkg::counter_update(chooser_table[train_idx], global_right);
		end
	end

endmodule

`default_nettype wire

// File: hdl/global_predictor.sv
`timescale 1ns/1ns
`default_nettype none

// Gshare with a history register updated only at resolve
module global_predictor #(
	parameter int global_history_bits = 6
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        lookup_valid,
	input  wire logic [branch_pkg::xlen-1:0] lookup_pc,
	input  wire logic [branch_pkg::xlen-1:0] train_pc,
	input  wire logic                        train_valid,
	input  wire logic                        train_taken,
	output logic                             global_taken
);

	localparam int counter_entries = 2 ** global_history_bits;

	branch_pkg::counter_e           counter_table [counter_entries];
	logic [global_history_bits-1:0] ghr;
	logic [global_history_bits-1:0] lookup_idx;
	logic [global_history_bits-1:0] train_idx;

	assign lookup_idx = lookup_pc[2 +: global_history_bits] ^ ghr;
	assign train_idx  = train_pc[2 +: global_history_bits] ^ ghr;  // Same GHR as the lookup

	always_ff @(posedge clock) begin
		if (lookup_valid)
			global_taken <= branch_pkg::counter_taken(counter_table[lookup_idx]);
	end

	always_ff @(posedge clock) begin
		if (reset)
			ghr <= '0;
		else if (train_valid)
			ghr <= global_history_bits'({ghr, train_taken});
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < counter_entries; i++)
				counter_table[i] <= branch_pkg::weak_not_taken;
		end else if (train_valid) begin
			counter_table[train_idx] <=
				branch_pkg::counter_update(counter_table[train_idx], train_taken);
		end
	end

	// An X on the training path would corrupt GHR and table for good
	train_inputs_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(train_valid) &&
		(train_valid -> !$isunknown({train_pc, train_taken})));

endmodule

`default_nettype wire

// File: hdl/local_predictor.sv
`timescale 1ns/1ns
`default_nettype none

// Two-level local predictor where per-PC history selects a shared counter
module local_predictor #(
	parameter int local_index_bits   = 6,
	parameter int local_history_bits = 4
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        lookup_valid,
	input  wire logic [branch_pkg::xlen-1:0] lookup_pc,
	input  wire logic [branch_pkg::xlen-1:0] train_pc,
	input  wire logic                        train_valid,
	input  wire logic                        train_taken,
	output logic                             local_taken
);

	localparam int history_entries = 2 ** local_index_bits;
	localparam int counter_entries = 2 ** local_history_bits;

	logic [local_history_bits-1:0] history_table [history_entries];
	branch_pkg::counter_e          counter_table [counter_entries];

	logic [local_index_bits-1:0]   lookup_idx;
	logic [local_index_bits-1:0]   train_idx;
	logic [local_history_bits-1:0] lookup_hist;
	logic [local_history_bits-1:0] train_hist;
	logic [local_history_bits-1:0] train_hist_next;

	assign lookup_idx  = lookup_pc[2 +: local_index_bits];  // Skip byte offset
	assign train_idx   = train_pc[2 +: local_index_bits];
	assign lookup_hist = history_table[lookup_idx];
	assign train_hist  = history_table[train_idx];

	// Newest outcome enters at the LSB, oldest falls off the top
	assign train_hist_next = local_history_bits'({train_hist, train_taken});

	always_ff @(posedge clock) begin
		if (lookup_valid)
			local_taken <= branch_pkg::counter_taken(counter_table[lookup_hist]);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < history_entries; i++)
				history_table[i] <= '0;
		end else if (train_valid) begin
			history_table[train_idx] <= train_hist_next;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < counter_entries; i++)
				counter_table[i] <= branch_pkg::weak_not_taken;
		end else if (train_valid) begin
			// Counter picked by the history seen before this outcome
			counter_table[train_hist] <=
				branch_pkg::counter_update(counter_table[train_hist], train_taken);
		end
	end

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_cond (
	input  wire logic [branch_pkg::xlen-1:0] opa,
	input  wire logic [branch_pkg::xlen-1:0] opb,
	input  wire branch_pkg::branch_func_e    func,
	output logic                             cond
);

	always_comb begin
		cond = 1'b0;  // Unknown funct3 never branches
		case (func)
			branch_pkg::beq:  cond = opa == opb;
			branch_pkg::bne:  cond = opa != opb;
			branch_pkg::blt:  cond = $signed(opa) < $signed(opb);
			branch_pkg::bge:  cond = $signed(opa) >= $signed(opb);
			branch_pkg::bltu: cond = opa < opb;
			branch_pkg::bgeu: cond = opa >= opb;
			default:          cond = 1'b0;
		endcase
	end

endmodule

module branch_unit (
	input  wire logic                           clock,
	input  wire logic                           reset,
	input  wire logic                           issue_valid,
	input  wire logic                           cdb_broadcast_is_branch,
	input  wire logic [branch_pkg::xlen-1:0]    opa_value,
	input  wire logic [branch_pkg::xlen-1:0]    opb_value,
	input  wire logic [branch_pkg::xlen-1:0]    pc,
	input  wire logic [branch_pkg::xlen-1:0]    offset,
	input  wire logic [branch_pkg::xlen-1:0]    pred_next_pc,
	input  wire branch_pkg::branch_func_e       branch_func,
	input  wire logic [branch_pkg::prf_len-1:0] dest_preg_idx,
	input  wire logic [branch_pkg::rob_len-1:0] rob_idx,
	input  wire logic                           cond_branch,
	input  wire logic                           uncond_branch,
	input  wire logic                           local_pred_direction,
	input  wire logic                           global_pred_direction,
	output logic                                br_valid,
	output logic                                br_direction,
	output logic                                br_mis_pred,
	output logic                                br_cond_branch,
	output logic                                br_uncond_branch,
	output logic                                br_local_pred_direction,
	output logic                                br_global_pred_direction,
	output logic [branch_pkg::xlen-1:0]         br_target_pc,
	output logic [branch_pkg::xlen-1:0]         br_next_pc,
	output logic [branch_pkg::xlen-1:0]         br_pc,
	output logic [branch_pkg::prf_len-1:0]      br_prf_idx,
	output logic [branch_pkg::rob_len-1:0]      br_rob_idx,
	output logic                                br_retire
);

	logic [branch_pkg::xlen-1:0] opa_q;
	logic [branch_pkg::xlen-1:0] opb_q;
	logic [branch_pkg::xlen-1:0] offset_q;
	logic [branch_pkg::xlen-1:0] pred_next_pc_q;
	branch_pkg::branch_func_e    func_q;
	logic                        cond;

	branch_cond branch_cond_inst (
		.opa  (opa_q),
		.opb  (opb_q),
		.func (func_q),
		.cond (cond)
	);

	// Capture the issued packet
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			opa_q                    <= opa_value;
			opb_q                    <= opb_value;
			offset_q                 <= offset;
			pred_next_pc_q           <= pred_next_pc;
			func_q                   <= branch_func;
			br_pc                    <= pc;
			br_prf_idx               <= dest_preg_idx;
			br_rob_idx               <= rob_idx;
			br_cond_branch           <= cond_branch;
			br_uncond_branch         <= uncond_branch;
			br_local_pred_direction  <= local_pred_direction;
			br_global_pred_direction <= global_pred_direction;
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			br_valid <= 1'b0;
		else if (issue_valid)
			br_valid <= 1'b1;  // Issue wins over broadcast
		else if (cdb_broadcast_is_branch)
			br_valid <= 1'b0;
	end

	assign br_direction = br_cond_branch ? cond : 1'b1;  // Jumps always taken
	assign br_target_pc = br_pc + offset_q;
	assign br_next_pc   = br_direction ? br_target_pc : br_pc + branch_pkg::xlen'(4);
	assign br_mis_pred  = pred_next_pc_q != br_next_pc;  // Catches wrong not-taken too
	assign br_retire    = br_valid && cdb_broadcast_is_branch;

	// Only one branch can be held; the RS must wait for the broadcast
	issue_while_held: assert property (@(posedge clock) disable iff (reset)
		issue_valid && br_valid |-> cdb_broadcast_is_branch);

	branch_kind_onehot: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> !(cond_branch && uncond_branch));

endmodule

`default_nettype wire

// File: hdl/branch_pkg.sv
`default_nettype none

package branch_pkg;

	parameter int xlen    = 32;  // Data and PC width
	parameter int prf_len = 6;   // Physical register index
	parameter int rob_len = 5;   // ROB index

	// funct3 of the RISC-V conditional branches
	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_func_e;

	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,
		weak_not_taken   = 2'b01,
		weak_taken       = 2'b10,
		strong_taken     = 2'b11
	} counter_e;

	// Upper half of the counter range predicts taken
	function automatic logic counter_taken(input counter_e c);
		return c[1];
	endfunction

	// One step toward the outcome, saturating at both ends
	function automatic counter_e counter_update(input counter_e c, input logic taken);
		counter_e n;
		n = c;
		case (c)
			strong_not_taken: n = taken ? weak_not_taken : strong_not_taken;
			weak_not_taken:   n = taken ? weak_taken     : strong_not_taken;
			weak_taken:       n = taken ? strong_taken   : weak_not_taken;
			strong_taken:     n = taken ? strong_taken   : weak_taken;
			default:          n = weak_not_taken;
		endcase
		return n;
	endfunction

endpackage

`default_nettype wire
